// File: hw/gfx_params.svh
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

// Shader datapath.
`define SHADER_LANES     4
`define FPINT_STAGES     3

// Raster geometry, 1024 pixel lines in 32 pixel tiles.
`define RASTER_X_BITS    10
`define RASTER_TILE_BITS 5

`endif

// File: hw/gfx_pkg.sv
package gfx_pkg;

	// IEEE 754 single precision layout.
	typedef struct packed {
		logic        sign;
		logic [7:0]  exponent;
		logic [22:0] mantissa;
	} float_fields;

	// One lane word, read either as an integer or as float fields.
	typedef union packed {
		logic signed [31:0] i;
		float_fields        f;
	} word;

endpackage

// File: hw/gfx_fpint_lane.sv
`timescale 1ns/100ps

module gfx_fpint_lane
(
	input  logic         clk,
	input  logic         reset,

	input  gfx_pkg::word a,
	input  gfx_pkg::word b,

	input  logic         minmax_abs,
	input  logic         minmax_swap,
	input  logic         minmax_zero_min,

	input  logic         addsub_enable,
	input  logic         addsub_sub,

	input  logic         shiftr_enable,
	input  logic         shiftr_int_signed,
	input  logic         clz_enable,

	output gfx_pkg::word q
);

	gfx_pkg::word a_abs;
	gfx_pkg::word b_abs;
	gfx_pkg::word lo;
	gfx_pkg::word hi;

	gfx_pkg::word x_q;
	gfx_pkg::word y_q;
	gfx_pkg::word s_q;
	gfx_pkg::word y2_q;

	gfx_pkg::word shifted;
	logic [4:0]   shamt;

	function automatic logic [5:0] clz32(input logic [31:0] v);
		logic [5:0] n;
		logic       found;

		n = 6'd0;
		found = 1'b0;
		for (int i = 31; i >= 0; i--) begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 6'd1;
		end
		return n;
	endfunction

	// ------------------------------------------------------------------------
	// Stage 1: abs, min/max ordering, swap and zero-min.

	always_comb begin
		a_abs = a;
		b_abs = b;
		if (minmax_abs) begin
			a_abs.f.sign = 1'b0; // Float abs.
			b_abs.f.sign = 1'b0;
		end

		if (a_abs.i < b_abs.i) begin
			lo = a_abs;
			hi = b_abs;
		end else begin
			lo = b_abs;
			hi = a_abs;
		end

		if (minmax_zero_min)
			lo.i = '0;
	end

	always_ff @(posedge clk) begin
		x_q <= minmax_swap ? hi : lo;
		y_q <= minmax_swap ? lo : hi;
	end

	// ------------------------------------------------------------------------
	// Stage 2: add or subtract, y rides along as the shift amount.

	always_ff @(posedge clk) begin
		if (!addsub_enable)
			s_q <= x_q;
		else if (addsub_sub)
			s_q.i <= x_q.i - y_q.i;
		else
			s_q.i <= x_q.i + y_q.i;

		y2_q <= y_q;
	end

	// ------------------------------------------------------------------------
	// Stage 3: clz, else shift right, else pass.

	assign shamt = y2_q.i[4:0];

	always_comb begin
		if (shiftr_int_signed)
			shifted.i = s_q.i >>> shamt; // Sign fill.
		else
			shifted.i = s_q.i >> shamt;
	end

	always_ff @(posedge clk) begin
		if (reset)
			q <= '0;
		else if (clz_enable)
			q.i <= {26'd0, clz32(s_q.i)};
		else if (shiftr_enable)
			q <= shifted;
		else
			q <= s_q;
	end

endmodule

// File: hw/gfx_fpint.sv
`timescale 1ns/100ps
`include "gfx_params.svh"

module gfx_fpint
(
	input  logic         clk,
	input  logic         reset,

	input  logic         in_valid,
	input  gfx_pkg::word a[`SHADER_LANES],
	input  gfx_pkg::word b[`SHADER_LANES],

	input  logic         minmax_abs,
	input  logic         minmax_swap,
	input  logic         minmax_zero_min,
	input  logic         addsub_enable,
	input  logic         addsub_sub,
	input  logic         shiftr_enable,
	input  logic         shiftr_int_signed,
	input  logic         clz_enable,

	output logic         out_valid,
	output gfx_pkg::word q[`SHADER_LANES]
);

	logic [`FPINT_STAGES-1:0] valid_q;

	logic s2_addsub_enable;
	logic s2_addsub_sub;
	logic s2_shiftr_enable;
	logic s2_shiftr_int_signed;
	logic s2_clz_enable;

	logic s3_shiftr_enable;
	logic s3_shiftr_int_signed;
	logic s3_clz_enable;

	assign out_valid = valid_q[`FPINT_STAGES-1];

	// Stage 1 flags are used straight from the ports at issue.
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			s2_addsub_enable <= 1'b0;
			s2_addsub_sub <= 1'b0;
			s2_shiftr_enable <= 1'b0;
			s2_shiftr_int_signed <= 1'b0;
			s2_clz_enable <= 1'b0;
			s3_shiftr_enable <= 1'b0;
			s3_shiftr_int_signed <= 1'b0;
			s3_clz_enable <= 1'b0;
		end else begin
			valid_q <= {valid_q[`FPINT_STAGES-2:0], in_valid};

			if (in_valid) begin
				s2_addsub_enable <= addsub_enable;
				s2_addsub_sub <= addsub_sub;
				s2_shiftr_enable <= shiftr_enable;
				s2_shiftr_int_signed <= shiftr_int_signed;
				s2_clz_enable <= clz_enable;
			end

			if (valid_q[0]) begin // Op leaving stage 2.
				s3_shiftr_enable <= s2_shiftr_enable;
				s3_shiftr_int_signed <= s2_shiftr_int_signed;
				s3_clz_enable <= s2_clz_enable;
			end
		end
	end

	for (genvar i = 0; i < `SHADER_LANES; i++) begin : lanes
		gfx_fpint_lane lane
		(
			.clk,
			.reset,
			.a(a[i]),
			.b(b[i]),
			.minmax_abs,
			.minmax_swap,
			.minmax_zero_min,
			.addsub_enable(s2_addsub_enable),
			.addsub_sub(s2_addsub_sub),
			.shiftr_enable(s3_shiftr_enable),
			.shiftr_int_signed(s3_shiftr_int_signed),
			.clz_enable(s3_clz_enable),
			.q(q[i])
		);
	end

endmodule

// File: hw/gfx_raster.sv
`timescale 1ns/100ps
`include "gfx_params.svh"

module gfx_raster
(
	input  logic         clk,
	input  logic         reset,

	input  gfx_pkg::word geom_tdata,
	input  logic         geom_tvalid,
	input  logic         geom_tlast,
	output logic         geom_tready,

	input  logic         raster_tready,
	output gfx_pkg::word raster_tdata,
	output logic         raster_tvalid,
	output logic         raster_tlast
);

	localparam int TILE_IDX_BITS = `RASTER_X_BITS - `RASTER_TILE_BITS;
	localparam int TILE_PIXELS = 1 << `RASTER_TILE_BITS;

	logic                         busy;
	logic                         span_last;
	logic [`RASTER_X_BITS-1:0]    x_a;
	logic [`RASTER_X_BITS-1:0]    x_b;
	logic [`RASTER_X_BITS-1:0]    min_x;
	logic [`RASTER_X_BITS-1:0]    max_x;
	logic [`RASTER_X_BITS-1:0]    span_lo;
	logic [`RASTER_X_BITS-1:0]    span_hi;
	logic [TILE_IDX_BITS-1:0]     tile;
	logic [TILE_IDX_BITS-1:0]     end_tile;
	logic [`RASTER_TILE_BITS-1:0] first_px;
	logic [`RASTER_TILE_BITS-1:0] last_px;
	logic                         at_end;
	logic [TILE_PIXELS-1:0]       mask;

	// ------------------------------------------------------------------------
	// Span decode.

	assign x_a = geom_tdata.i[`RASTER_X_BITS-1:0];
	assign x_b = geom_tdata.i[16 +: `RASTER_X_BITS];

	assign min_x = x_a < x_b ? x_a : x_b;
	assign max_x = x_a < x_b ? x_b : x_a;

	// ------------------------------------------------------------------------
	// Tile mask, bounds clipped to the current tile.

	assign end_tile = span_hi[`RASTER_X_BITS-1:`RASTER_TILE_BITS];
	assign at_end = tile == end_tile;

	assign first_px = tile == span_lo[`RASTER_X_BITS-1:`RASTER_TILE_BITS]
		? span_lo[`RASTER_TILE_BITS-1:0] : '0;
	assign last_px = at_end ? span_hi[`RASTER_TILE_BITS-1:0] : '1;

	assign mask = ({TILE_PIXELS{1'b1}} << first_px)
		& ({TILE_PIXELS{1'b1}} >> (TILE_PIXELS - 1 - last_px));

	assign raster_tdata = mask;
	assign raster_tvalid = busy;
	assign raster_tlast = busy && span_last && at_end;
	assign geom_tready = !busy; // Take a span only when idle.

	// ------------------------------------------------------------------------
	// Idle/busy state.

	always_ff @(posedge clk) begin
		if (reset)
			busy <= 1'b0;
		else if (!busy)
			busy <= geom_tvalid;
		else if (raster_tready && at_end)
			busy <= 1'b0; // Last tile taken.
	end

	always_ff @(posedge clk) begin
		if (!busy && geom_tvalid) begin
			span_lo <= min_x;
			span_hi <= max_x;
			span_last <= geom_tlast;
			tile <= min_x[`RASTER_X_BITS-1:`RASTER_TILE_BITS];
		end else if (busy && raster_tready && !at_end) begin
			tile <= tile + 1'b1;
		end
	end

endmodule

// File: hw/w3d_top.sv
`timescale 1ns/100ps
`include "gfx_params.svh"

module w3d_top
(
	input  logic         clk,
	input  logic         reset,

	input  gfx_pkg::word a[`SHADER_LANES],
	input  gfx_pkg::word b[`SHADER_LANES],
	input  logic         in_valid,
	input  logic         minmax_abs,
	input  logic         minmax_swap,
	input  logic         minmax_zero_min,
	input  logic         addsub_enable,
	input  logic         addsub_sub,
	input  logic         shiftr_enable,
	input  logic         shiftr_int_signed,
	input  logic         clz_enable,

	output logic         out_valid,
	output gfx_pkg::word q[`SHADER_LANES],

	input  gfx_pkg::word geom_tdata,
	input  logic         geom_tlast,
	input  logic         geom_tvalid,
	output logic         geom_tready,

	input  logic         raster_tready,
	output logic         raster_tlast,
	output logic         raster_tvalid,
	output gfx_pkg::word raster_tdata
);

	// Lane pipeline.
	gfx_fpint fpint
	(
		.clk,
		.reset,
		.in_valid,
		.a,
		.b,
		.minmax_abs,
		.minmax_swap,
		.minmax_zero_min,
		.addsub_enable,
		.addsub_sub,
		.shiftr_enable,
		.shiftr_int_signed,
		.clz_enable,
		.out_valid,
		.q
	);

	// Span rasterizer.
	gfx_raster raster
	(
		.clk,
		.reset,
		.geom_tdata,
		.geom_tvalid,
		.geom_tlast,
		.geom_tready,
		.raster_tready,
		.raster_tdata,
		.raster_tvalid,
		.raster_tlast
	);

endmodule

// File: tb/w3d_top_tb.sv
`timescale 1ns/100ps
`include "gfx_params.svh"

module w3d_top_tb;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_CYCLES = 3000;
	localparam int X_BITS = `RASTER_X_BITS;
	localparam int TILE_BITS = `RASTER_TILE_BITS;

	logic         clk;
	logic         reset;

	gfx_pkg::word a[`SHADER_LANES];
	gfx_pkg::word b[`SHADER_LANES];
	logic         in_valid;
	logic         minmax_abs;
	logic         minmax_swap;
	logic         minmax_zero_min;
	logic         addsub_enable;
	logic         addsub_sub;
	logic         shiftr_enable;
	logic         shiftr_int_signed;
	logic         clz_enable;
	logic         out_valid;
	gfx_pkg::word q[`SHADER_LANES];

	gfx_pkg::word geom_tdata;
	logic         geom_tlast;
	logic         geom_tvalid;
	logic         geom_tready;
	logic         raster_tready;
	logic         raster_tlast;
	logic         raster_tvalid;
	gfx_pkg::word raster_tdata;

	logic [31:0]  lfsr = 32'hd76a13b6;
	int           cycle = 0;
	int           op_count = 0;
	int           tile_total = 0;
	logic         geom_taken = 1'b0;

	// Expected fpint results, lane words in issue order.
	int           due_q[$];
	gfx_pkg::word word_q[$];

	// Expected tiles as {last, mask}.
	logic [32:0]  tile_q[$];

	logic         held = 1'b0;
	gfx_pkg::word held_data;
	logic         held_last;

	w3d_top i_dut
	(
		.clk(clk),
		.reset(reset),
		.a(a),
		.b(b),
		.in_valid(in_valid),
		.minmax_abs(minmax_abs),
		.minmax_swap(minmax_swap),
		.minmax_zero_min(minmax_zero_min),
		.addsub_enable(addsub_enable),
		.addsub_sub(addsub_sub),
		.shiftr_enable(shiftr_enable),
		.shiftr_int_signed(shiftr_int_signed),
		.clz_enable(clz_enable),
		.out_valid(out_valid),
		.q(q),
		.geom_tdata(geom_tdata),
		.geom_tlast(geom_tlast),
		.geom_tvalid(geom_tvalid),
		.geom_tready(geom_tready),
		.raster_tready(raster_tready),
		.raster_tlast(raster_tlast),
		.raster_tvalid(raster_tvalid),
		.raster_tdata(raster_tdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Random bits and reference models.

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;

		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int count_leading_zeros(input logic [31:0] v);
		int n;

		n = 0;
		while (n < 32 && v[31 - n] == 1'b0)
			n++;
		return n;
	endfunction

	function automatic gfx_pkg::word lane_model(input gfx_pkg::word op_a,
		input gfx_pkg::word op_b, input logic abs_f, input logic swap_f,
		input logic zmin_f, input logic add_f, input logic sub_f,
		input logic shr_f, input logic sgn_f, input logic clz_f);
		logic signed [31:0] va;
		logic signed [31:0] vb;
		logic signed [31:0] lo;
		logic signed [31:0] hi;
		logic signed [31:0] x;
		logic signed [31:0] y;
		logic signed [31:0] s;
		gfx_pkg::word       r;

		va = op_a;
		vb = op_b;
		if (abs_f) begin
			va[31] = 1'b0;
			vb[31] = 1'b0;
		end
		lo = (va < vb) ? va : vb;
		hi = (va < vb) ? vb : va;
		if (zmin_f)
			lo = 0;
		x = swap_f ? hi : lo;
		y = swap_f ? lo : hi;

		if (!add_f)
			s = x;
		else
			s = sub_f ? x - y : x + y;

		if (clz_f)
			r.i = count_leading_zeros(s);
		else if (shr_f && sgn_f)
			r.i = s >>> y[4:0];
		else if (shr_f)
			r.i = $unsigned(s) >> y[4:0];
		else
			r.i = s;
		return r;
	endfunction

	task automatic expand_span(input gfx_pkg::word data, input logic last);
		int          xa;
		int          xb;
		int          lo;
		int          hi;
		logic [31:0] mask;

		xa = data.i[X_BITS-1:0];
		xb = data.i[16 +: X_BITS];
		lo = (xa < xb) ? xa : xb;
		hi = (xa < xb) ? xb : xa;
		for (int t = lo >> TILE_BITS; t <= hi >> TILE_BITS; t++) begin
			mask = '0;
			for (int p = 0; p < 32; p++)
				mask[p] = (t * 32 + p >= lo) && (t * 32 + p <= hi);
			tile_q.push_back({last && (t == hi >> TILE_BITS), mask});
			tile_total++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Compare tasks.

	task automatic mismatch(input string msg);
		$display("CHECK FAILED at %0d ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_word(input int lane, input gfx_pkg::word got,
		input gfx_pkg::word exp);
		if (got !== exp)
			mismatch($sformatf("lane %0d q is %h, expected %h", lane, got, exp));
	endtask

	task automatic check_valid(input string what, input logic got, input logic exp);
		if (got !== exp)
			mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_tile(input string what, input gfx_pkg::word got,
		input logic got_last, input gfx_pkg::word exp, input logic exp_last);
		if (got !== exp || got_last !== exp_last)
			mismatch($sformatf("%s tile %h last %b, expected %h last %b",
				what, got, got_last, exp, exp_last));
	endtask

	// ------------------------------------------------------------------------
	// Stimulus, driven on the falling edge.

	task automatic drive_inputs(input bit stim);
		int          phase;
		logic [31:0] xa;
		logic [31:0] xb;
		logic [1:0]  kind;

		phase = cycle * 3 / NUM_CYCLES;
		raster_tready = take_bits(1);
		in_valid = stim && take_bits(2) != 0;
		minmax_abs = take_bits(1);
		minmax_swap = take_bits(1);
		minmax_zero_min = take_bits(2) == 0;
		addsub_enable = (phase == 1) ? take_bits(2) != 0 : (phase == 2) && take_bits(2) == 0;
		addsub_sub = take_bits(1);
		shiftr_enable = (phase == 2) && take_bits(1);
		shiftr_int_signed = take_bits(1);
		clz_enable = (phase == 2) && take_bits(1);
		for (int l = 0; l < `SHADER_LANES; l++) begin
			kind = take_bits(2);
			if (phase == 2 && kind == 0)
				a[l] = '0;
			else if (phase == 2 && kind == 1)
				a[l] = 32'd1 << take_bits(5);
			else
				a[l] = take_bits(32);
			b[l] = take_bits(32);
		end

		if (geom_tvalid && geom_taken)
			geom_tvalid = 1'b0;
		geom_taken = 1'b0;
		if (!geom_tvalid && stim && take_bits(2) != 0) begin
			kind = take_bits(2);
			xa = take_bits(X_BITS);
			case (kind)
				2'd0: xb = take_bits(X_BITS);
				2'd1: xb = xa; // Single pixel.
				2'd2: begin
					xb = take_bits(TILE_BITS);
					xb[X_BITS-1:TILE_BITS] = xa[X_BITS-1:TILE_BITS];
				end
				default: xb = xa + take_bits(7);
			endcase
			geom_tdata = take_bits(32); // Junk in the unused bits.
			geom_tdata.i[X_BITS-1:0] = xa[X_BITS-1:0];
			geom_tdata.i[16 +: X_BITS] = xb[X_BITS-1:0];
			geom_tlast = take_bits(1);
			geom_tvalid = 1'b1;
		end
	endtask

	// ------------------------------------------------------------------------
	// Checks at the rising edge, before the DUT registers update.

	task automatic check_outputs();
		logic        exp_v;
		logic [32:0] t;

		exp_v = due_q.size() != 0 && due_q[0] == cycle;
		check_valid("out_valid", out_valid, exp_v);
		if (exp_v) begin
			void'(due_q.pop_front());
			for (int l = 0; l < `SHADER_LANES; l++)
				check_word(l, q[l], word_q.pop_front());
		end
		if (in_valid) begin
			due_q.push_back(cycle + `FPINT_STAGES);
			op_count++;
			for (int l = 0; l < `SHADER_LANES; l++)
				word_q.push_back(lane_model(a[l], b[l], minmax_abs, minmax_swap,
					minmax_zero_min, addsub_enable, addsub_sub, shiftr_enable,
					shiftr_int_signed, clz_enable));
		end

		if (held)
			check_tile("held", raster_tdata, raster_tlast, held_data, held_last);
		check_valid("raster_tvalid", raster_tvalid, tile_q.size() != 0);
		check_valid("geom_tready", geom_tready, tile_q.size() == 0);
		if (raster_tvalid && raster_tready) begin
			t = tile_q.pop_front();
			check_tile("accepted", raster_tdata, raster_tlast, t[31:0], t[32]);
		end
		held = raster_tvalid && !raster_tready;
		held_data = raster_tdata;
		held_last = raster_tlast;

		if (geom_tvalid && geom_tready) begin
			expand_span(geom_tdata, geom_tlast);
			geom_taken = 1'b1;
		end
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		minmax_abs = 1'b0;
		minmax_swap = 1'b0;
		minmax_zero_min = 1'b0;
		addsub_enable = 1'b0;
		addsub_sub = 1'b0;
		shiftr_enable = 1'b0;
		shiftr_int_signed = 1'b0;
		clz_enable = 1'b0;
		for (int l = 0; l < `SHADER_LANES; l++) begin
			a[l] = '0;
			b[l] = '0;
		end
		geom_tdata = '0;
		geom_tlast = 1'b0;
		geom_tvalid = 1'b0;
		raster_tready = 1'b0;

		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_valid("out_valid after reset", out_valid, 1'b0);
		check_valid("raster_tvalid after reset", raster_tvalid, 1'b0);
		check_valid("geom_tready after reset", geom_tready, 1'b1);

		// Stimulus phase, then drain everything in flight.
		while (cycle < NUM_CYCLES || due_q.size() != 0 || tile_q.size() != 0
			|| geom_tvalid) begin
			@(negedge clk);
			drive_inputs(cycle < NUM_CYCLES);
			@(posedge clk);
			check_outputs();
			cycle++;
		end

		$display("Done: no errors");
		$finish;
	end

	initial begin : watchdog
		longint limit;

		limit = 0;
		do begin
			@(posedge clk);
			limit = longint'(op_count + tile_total + 100) * 4 * CLK_PERIOD;
		end while ($time < limit);
		$display("Watchdog timeout: the run did not finish within %0d ns.", limit);
		$display("Done: errors found");
		$fatal(1, "watchdog timeout");
	end

endmodule

// File: verilog.f
+incdir+hw
hw/gfx_pkg.sv
hw/gfx_fpint_lane.sv
hw/gfx_fpint.sv
hw/gfx_raster.sv
hw/w3d_top.sv
tb/w3d_top_tb.sv

// File: Bender.yml
package:
  name: w3d_top

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/gfx_pkg.sv
      - hw/gfx_fpint_lane.sv
      - hw/gfx_fpint.sv
      - hw/gfx_raster.sv
      - hw/w3d_top.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tb/w3d_top_tb.sv
